//--- verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    localparam int OPCODE_W = 7;
    localparam int COND_W = 4;

    // condition codes handled outside the flag table
    localparam logic [COND_W-1:0] COND_ALWAYS = 4'b1110;
    localparam logic [COND_W-1:0] COND_NEVER = 4'b1111;

    // low opcode nibble of a compare, result is not written back
    localparam logic [3:0] OPC_CMP_LOW = 4'b1010;

    // pc source select
    localparam logic [1:0] PC_SEL_INC = 2'b00;
    localparam logic [1:0] PC_SEL_START = 2'b01;
    localparam logic [1:0] PC_SEL_BRANCH = 2'b11;

    // processor step, one clock each
    typedef enum logic [3:0] {
        step_reset = 4'd0,
        step_fetch = 4'd1,
        step_fetch_wait = 4'd2,
        step_decode = 4'd3,
        step_execute = 4'd4,
        step_mem_pc = 4'd5,
        step_mem_wait = 4'd6,
        step_write_back = 4'd7,
        step_load_pc_start = 4'd8
    } step_t;

    // instruction class seen by the control blocks
    typedef enum logic [2:0] {
        cls_none = 3'd0,
        cls_alu = 3'd1,
        cls_load = 3'd2,
        cls_store = 3'd3,
        cls_branch = 3'd4
    } instr_class_t;

    // alu operation encoding
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_orr = 3'b011,
        alu_xor = 3'b111
    } alu_op_t;

endpackage

//--- verilog/instr_if.sv
`timescale 1ns/1ps

interface instr_if
    import cpu_ctrl_pkg::*;
();

    // classified instruction, valid while the decoded fields are held
    instr_class_t cls;
    logic [OPCODE_W-1:0] opcode;
    logic [COND_W-1:0] cond;
    // indexing bits for load/store
    logic p;
    logic u;
    logic w;

    modport src (output cls, output opcode, output cond, output p, output u, output w);

    modport dst (input cls, input opcode, input cond, input p, input u, input w);

endinterface

//--- verilog/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier
    import cpu_ctrl_pkg::*;
(
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [COND_W-1:0]   cond,
    input  logic                p,
    input  logic                u,
    input  logic                w,
    instr_if.src                instr
);

    // raw fields go through unchanged
    assign instr.opcode = opcode;
    assign instr.cond = cond;
    assign instr.p = p;
    assign instr.u = u;
    assign instr.w = w;

    // first matching rule wins
    always_comb begin
        if (opcode[6] == 1'b0 && cond != COND_NEVER) begin
            instr.cls = cls_alu;
        end else if (opcode[6:4] == 3'b111) begin
            instr.cls = cls_store;
        end else if (opcode[6:4] == 3'b110 || opcode[6:3] == 4'b1000) begin
            // literal load shares the load path
            instr.cls = cls_load;
        end else if (opcode[6:3] == 4'b1001) begin
            instr.cls = cls_branch;
        end else begin
            instr.cls = cls_none;
        end
    end

endmodule

//--- verilog/step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  instr_class_t cls,
    output step_t        step,
    output logic         load_ir,
    output logic         status_rdy,
    output logic         w_en_ldr,
    output logic         start_load_pc
);

    step_t step_next;

    // fixed linear sequence without stalls
    always_comb begin
        case (step)
            step_reset:         step_next = step_load_pc_start;
            step_load_pc_start: step_next = step_fetch;
            step_fetch:         step_next = step_fetch_wait;
            step_fetch_wait:    step_next = step_decode;
            step_decode:        step_next = step_execute;
            step_execute:       step_next = step_mem_pc;
            step_mem_pc:        step_next = step_mem_wait;
            step_mem_wait:      step_next = step_write_back;
            step_write_back:    step_next = step_fetch;
            // recover from an illegal encoding
            default:            step_next = step_reset;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= step_reset;
        end else begin
            step <= step_next;
        end
    end

    // strobes that depend on the step alone
    assign start_load_pc = (step == step_load_pc_start);
    assign load_ir = (step == step_decode);
    assign status_rdy = (step == step_mem_wait);
    // load data lands in the register file at write-back
    assign w_en_ldr = (step == step_write_back) && (cls == cls_load);

    a_step_legal: assert property (@(posedge clk) disable iff (!rst_n)
        step inside {step_reset, step_fetch, step_fetch_wait, step_decode,
                     step_execute, step_mem_pc, step_mem_wait, step_write_back,
                     step_load_pc_start});

endmodule

//--- verilog/cond_check.sv
`timescale 1ns/1ps

module cond_check
    import cpu_ctrl_pkg::*;
(
    instr_if.dst       instr,
    input  logic [3:0] flags,
    output logic       taken
);

    logic n;
    logic z;
    logic c;
    logic v;

    // flags arrive as status bits 31 to 28
    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    always_comb begin
        case (instr.cond)
            4'b0000:     taken = z;
            4'b0001:     taken = ~z;
            4'b0010:     taken = c;
            4'b0011:     taken = ~c;
            4'b0100:     taken = n;
            4'b0101:     taken = ~n;
            4'b0110:     taken = v;
            4'b0111:     taken = ~v;
            4'b1000:     taken = c & ~z;
            // ls, unsigned lower or same
            4'b1001:     taken = ~c | z;
            4'b1010:     taken = (n == v);
            4'b1011:     taken = (n != v);
            4'b1100:     taken = ~z & (n == v);
            4'b1101:     taken = z | (n != v);
            COND_ALWAYS: taken = 1'b1;
            COND_NEVER:  taken = 1'b0;
            default:     taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/operand_control.sv
`timescale 1ns/1ps

module operand_control
    import cpu_ctrl_pkg::*;
(
    instr_if.dst  instr,
    input  step_t step,
    output logic  en_a,
    output logic  en_b,
    output logic  en_s,
    output logic  sel_shift
);

    always_comb begin
        en_a = 1'b0;
        en_b = 1'b0;
        en_s = 1'b0;
        sel_shift = 1'b0;

        // operand registers load only in execute
        if (step == step_execute) begin
            case (instr.cls)
                cls_alu: begin
                    en_a = instr.opcode[3];
                    en_b = instr.opcode[4];
                    en_s = 1'b1;
                    // immediate form shifts by zero
                    sel_shift = instr.opcode[4] ? instr.opcode[5] : 1'b0;
                end
                cls_load, cls_store: begin
                    // base register is always read
                    en_a = 1'b1;
                    if (instr.opcode[3]) begin
                        // register offset with shift
                        en_b = 1'b1;
                        en_s = 1'b1;
                        sel_shift = 1'b1;
                    end
                end
                default: begin
                    en_a = 1'b0;
                    en_b = 1'b0;
                    en_s = 1'b0;
                    sel_shift = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- verilog/execute_control.sv
`timescale 1ns/1ps

module execute_control
    import cpu_ctrl_pkg::*;
(
    instr_if.dst        instr,
    input  step_t       step,
    input  logic        taken,
    input  logic        en_status_decode,
    output alu_op_t     alu_op,
    output logic        sel_a,
    output logic        sel_b,
    output logic        sel_pre_indexed,
    output logic        sel_branch_imme,
    output logic        sel_load_lr,
    output logic        en_status,
    output logic        w_en1,
    output logic        ram_w_en,
    output logic        load_pc,
    output logic [1:0]  sel_pc
);

    always_comb begin
        alu_op = alu_add;
        sel_a = 1'b0;
        sel_b = 1'b0;
        sel_pre_indexed = 1'b0;
        sel_branch_imme = 1'b0;
        sel_load_lr = 1'b0;
        en_status = 1'b0;
        w_en1 = 1'b0;
        ram_w_en = 1'b0;
        load_pc = 1'b0;
        sel_pc = PC_SEL_INC;

        if (step == step_mem_pc) begin
            case (instr.cls)
                cls_alu: begin
                    load_pc = 1'b1;
                    case (instr.opcode[2:0])
                        3'b000:  alu_op = alu_add;
                        3'b001:  alu_op = alu_sub;
                        3'b010:  alu_op = alu_sub;
                        3'b011:  alu_op = alu_and;
                        3'b100:  alu_op = alu_orr;
                        3'b101:  alu_op = alu_xor;
                        default: alu_op = alu_add;
                    endcase
                    // immediate operand when the register was not loaded
                    sel_a = ~instr.opcode[3];
                    sel_b = ~instr.opcode[4];
                    en_status = en_status_decode;
                    // compare only updates flags
                    w_en1 = (instr.opcode[3:0] != OPC_CMP_LOW);
                end
                cls_load, cls_store: begin
                    load_pc = 1'b1;
                    // u picks the offset direction
                    alu_op = instr.u ? alu_add : alu_sub;
                    sel_pre_indexed = ~instr.p;
                    sel_b = ~instr.opcode[3];
                    en_status = en_status_decode;
                    // base write-back for pre-indexed with w set
                    w_en1 = instr.p & instr.w;
                    ram_w_en = (instr.cls == cls_store);
                end
                cls_branch: begin
                    load_pc = 1'b1;
                    sel_pc = taken ? PC_SEL_BRANCH : PC_SEL_INC;
                    // link register write
                    w_en1 = instr.opcode[2];
                    sel_load_lr = 1'b0;
                    // target is pc plus offset
                    alu_op = alu_add;
                    sel_a = 1'b1;
                    sel_b = ~instr.opcode[1];
                    sel_branch_imme = ~instr.opcode[1];
                    en_status = 1'b0;
                end
                default: begin
                    load_pc = 1'b0;
                end
            endcase
        end
    end

    // no ram write for anything but a store
    a_ram_w_store: assert property (@(step)
        ram_w_en |-> (instr.cls == cls_store));

endmodule

//--- verilog/cpu_controller.sv
`timescale 1ns/1ps

module cpu_controller
    import cpu_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [COND_W-1:0]   cond,
    input  logic [3:0]          flags,
    input  logic                p,
    input  logic                u,
    input  logic                w,
    input  logic                en_status_decode,
    output logic                w_en1,
    output logic                w_en_ldr,
    output logic                sel_load_lr,
    output logic                en_a,
    output logic                en_b,
    output logic                en_s,
    output logic                sel_shift,
    output logic                sel_a,
    output logic                sel_b,
    output logic                sel_branch_imme,
    output logic                sel_pre_indexed,
    output alu_op_t             alu_op,
    output logic                en_status,
    output logic                status_rdy,
    output logic                load_ir,
    output logic                load_pc,
    output logic [1:0]          sel_pc,
    output logic                ram_w_en
);

    step_t      step;
    logic       taken;
    logic       start_load_pc;
    logic       exec_load_pc;
    logic [1:0] exec_sel_pc;

    instr_if instr ();

    instr_classifier classifier_i (.opcode(opcode), .cond(cond), .p(p), .u(u), .w(w),
        .instr(instr.src));

    step_sequencer sequencer_i (.clk(clk), .rst_n(rst_n), .cls(instr.cls), .step(step),
        .load_ir(load_ir), .status_rdy(status_rdy), .w_en_ldr(w_en_ldr),
        .start_load_pc(start_load_pc));

    cond_check cond_i (.instr(instr.dst), .flags(flags), .taken(taken));

    operand_control operand_i (.instr(instr.dst), .step(step), .en_a(en_a), .en_b(en_b),
        .en_s(en_s), .sel_shift(sel_shift));

    execute_control execute_i (.instr(instr.dst), .step(step), .taken(taken),
        .en_status_decode(en_status_decode), .alu_op(alu_op), .sel_a(sel_a),
        .sel_b(sel_b), .sel_pre_indexed(sel_pre_indexed),
        .sel_branch_imme(sel_branch_imme), .sel_load_lr(sel_load_lr),
        .en_status(en_status), .w_en1(w_en1), .ram_w_en(ram_w_en),
        .load_pc(exec_load_pc), .sel_pc(exec_sel_pc));

    // startup load and per-instruction pc update never overlap
    assign load_pc = start_load_pc | exec_load_pc;
    assign sel_pc = start_load_pc ? PC_SEL_START : exec_sel_pc;

endmodule

//--- dv/ctrl_checker.sv
`timescale 1ns/1ps

module ctrl_checker
    import cpu_ctrl_pkg::*;
(
    input  logic                clk, rst_n,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [COND_W-1:0]   cond,
    input  logic [3:0]          flags,
    input  logic                p, u, w, en_status_decode,
    input  logic                w_en1, w_en_ldr, sel_load_lr, en_a, en_b, en_s, sel_shift,
    input  logic                sel_a, sel_b, sel_branch_imme, sel_pre_indexed,
    input  alu_op_t             alu_op,
    input  logic                en_status, status_rdy, load_ir, load_pc, ram_w_en,
    input  logic [1:0]          sel_pc,
    input  logic                test_done, all_done,
    output int                  error_count,
    output int                  check_count
);

    step_t        model_step;
    instr_class_t model_cls;
    logic         model_taken;
    logic         exp_w_en1, exp_w_en_ldr, exp_sel_load_lr, exp_en_a, exp_en_b, exp_en_s;
    logic         exp_sel_shift, exp_sel_a, exp_sel_b, exp_sel_branch_imme, exp_sel_pre_indexed;
    logic         exp_en_status, exp_status_rdy, exp_load_ir, exp_load_pc, exp_ram_w_en;
    logic [2:0]   exp_alu_op;
    logic [1:0]   exp_sel_pc;
    int           test_errors, test_instrs, tests_done;
    logic         summary_done;

    function automatic instr_class_t class_of(input logic [6:0] opc, input logic [3:0] c);
        if (!opc[6] && c != COND_NEVER) return cls_alu;
        if (opc[6:4] == 3'b111) return cls_store;
        if (opc[6:4] == 3'b110 || opc[6:3] == 4'b1000) return cls_load;
        if (opc[6:3] == 4'b1001) return cls_branch;
        return cls_none;
    endfunction

    // arm pairs each condition with its inverse in the low bit
    function automatic logic cond_holds(input logic [3:0] c, input logic [3:0] f);
        logic base;
        case (c[3:1])
            3'd0:    base = f[2];
            3'd1:    base = f[1];
            3'd2:    base = f[3];
            3'd3:    base = f[0];
            3'd4:    base = f[1] & ~f[2];
            3'd5:    base = (f[3] == f[0]);
            3'd6:    base = ~f[2] & (f[3] == f[0]);
            default: base = 1'b1;
        endcase
        return c[0] ? ~base : base;
    endfunction

    function automatic logic [2:0] alu_map(input logic [2:0] f);
        case (f)
            3'b001, 3'b010: return alu_sub;
            3'b011:         return alu_and;
            3'b100:         return alu_orr;
            3'b101:         return alu_xor;
            default:        return alu_add;
        endcase
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_step <= step_reset;
        end else if (model_step == step_reset) begin
            model_step <= step_load_pc_start;
        end else if (model_step == step_write_back || model_step == step_load_pc_start) begin
            model_step <= step_fetch;
        end else begin
            model_step <= step_t'(model_step + 4'd1);
        end
    end

    assign model_cls = class_of(opcode, cond);
    assign model_taken = cond_holds(cond, flags);

    always_comb begin
        {exp_w_en1, exp_w_en_ldr, exp_sel_load_lr, exp_en_a, exp_en_b, exp_en_s} = '0;
        {exp_sel_shift, exp_sel_a, exp_sel_b, exp_sel_branch_imme, exp_sel_pre_indexed} = '0;
        {exp_en_status, exp_status_rdy, exp_load_ir, exp_load_pc, exp_ram_w_en} = '0;
        exp_alu_op = alu_add;
        exp_sel_pc = PC_SEL_INC;
        if (model_step == step_load_pc_start) begin
            exp_load_pc = 1'b1;
            exp_sel_pc = PC_SEL_START;
        end
        exp_load_ir = (model_step == step_decode);
        exp_status_rdy = (model_step == step_mem_wait);
        exp_w_en_ldr = (model_step == step_write_back) && (model_cls == cls_load);
        if (model_step == step_execute && model_cls == cls_alu) begin
            exp_en_a = opcode[3];
            exp_en_b = opcode[4];
            exp_en_s = 1'b1;
            exp_sel_shift = opcode[4] & opcode[5];
        end else if (model_step == step_execute && model_cls inside {cls_load, cls_store}) begin
            exp_en_a = 1'b1;
            {exp_en_b, exp_en_s, exp_sel_shift} = {3{opcode[3]}};
        end
        if (model_step == step_mem_pc && model_cls == cls_alu) begin
            exp_load_pc = 1'b1;
            exp_alu_op = alu_map(opcode[2:0]);
            exp_sel_a = ~opcode[3];
            exp_sel_b = ~opcode[4];
            exp_en_status = en_status_decode;
            exp_w_en1 = (opcode[3:0] != OPC_CMP_LOW);
        end else if (model_step == step_mem_pc && model_cls inside {cls_load, cls_store}) begin
            exp_load_pc = 1'b1;
            exp_alu_op = u ? alu_add : alu_sub;
            exp_sel_pre_indexed = ~p;
            exp_sel_b = ~opcode[3];
            exp_en_status = en_status_decode;
            exp_w_en1 = p & w;
            exp_ram_w_en = (model_cls == cls_store);
        end else if (model_step == step_mem_pc && model_cls == cls_branch) begin
            exp_load_pc = 1'b1;
            exp_sel_pc = model_taken ? PC_SEL_BRANCH : PC_SEL_INC;
            exp_w_en1 = opcode[2];
            exp_sel_a = 1'b1;
            exp_sel_b = ~opcode[1];
            exp_sel_branch_imme = ~opcode[1];
        end
    end

    task automatic check_vec(input string name, input logic [2:0] exp_v, input logic [2:0] act_v);
        check_count++;
        if (act_v !== exp_v) begin
            error_count++;
            test_errors++;
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        check_vec(name, {2'b00, exp_v}, {2'b00, act_v});
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        test_instrs = 0;
        tests_done = 0;
        summary_done = 1'b0;
    end

    // outputs are sampled before the step register moves
    always @(posedge clk) begin
        if (!$isunknown(model_step)) begin
            check_bit("w_en1", exp_w_en1, w_en1);
            check_bit("w_en_ldr", exp_w_en_ldr, w_en_ldr);
            check_bit("sel_load_lr", exp_sel_load_lr, sel_load_lr);
            check_bit("en_a", exp_en_a, en_a);
            check_bit("en_b", exp_en_b, en_b);
            check_bit("en_s", exp_en_s, en_s);
            check_bit("sel_shift", exp_sel_shift, sel_shift);
            check_bit("sel_a", exp_sel_a, sel_a);
            check_bit("sel_b", exp_sel_b, sel_b);
            check_bit("sel_branch_imme", exp_sel_branch_imme, sel_branch_imme);
            check_bit("sel_pre_indexed", exp_sel_pre_indexed, sel_pre_indexed);
            check_vec("alu_op", exp_alu_op, alu_op);
            check_bit("en_status", exp_en_status, en_status);
            check_bit("status_rdy", exp_status_rdy, status_rdy);
            check_bit("load_ir", exp_load_ir, load_ir);
            check_bit("load_pc", exp_load_pc, load_pc);
            check_vec("sel_pc", {1'b0, exp_sel_pc}, {1'b0, sel_pc});
            check_bit("ram_w_en", exp_ram_w_en, ram_w_en);
            if (model_step == step_decode) test_instrs++;
        end
        if (test_done) begin
            $display("test %0d finished: %0d instructions, %0d mismatches",
                     tests_done, test_instrs, test_errors);
            tests_done++;
            test_errors = 0;
            test_instrs = 0;
        end
        if (all_done && !summary_done) begin
            summary_done = 1'b1;
            $display("summary: %0d tests, %0d checks, %0d mismatches",
                     tests_done, check_count, error_count);
        end
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import cpu_ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 4;
    localparam int INSTR_PER_TEST = 200;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * INSTR_PER_TEST * 7 + 100;

    logic                clk, rst_n;
    logic [OPCODE_W-1:0] opcode;
    logic [COND_W-1:0]   cond;
    logic [3:0]          flags;
    logic                p, u, w, en_status_decode;
    logic                w_en1, w_en_ldr, sel_load_lr, en_a, en_b, en_s, sel_shift;
    logic                sel_a, sel_b, sel_branch_imme, sel_pre_indexed;
    alu_op_t             alu_op;
    logic                en_status, status_rdy, load_ir, load_pc, ram_w_en;
    logic [1:0]          sel_pc;
    logic                test_done, all_done;
    int                  error_count, check_count;
    logic [15:0]         lfsr;

    cpu_controller dut_i (.*);

    ctrl_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[14:0], lfsr[0]};
        end
    endtask

    // test 0 mixed, then data-processing, load/store and branch heavy
    task automatic drive_instr(input int test);
        logic [15:0] kind_r, bias_r, low_r, cond_r, flag_r, misc_r;
        logic [2:0]  kind;
        take_bits(3, kind_r);
        take_bits(2, bias_r);
        take_bits(6, low_r);
        take_bits(4, cond_r);
        take_bits(4, flag_r);
        take_bits(4, misc_r);
        kind = kind_r[2:0];
        if (bias_r[1:0] != 2'b00) begin
            case (test)
                1:       kind = 3'd0;
                2:       kind = bias_r[0] ? 3'd3 : 3'd4;
                3:       kind = 3'd6;
                default: kind = kind_r[2:0];
            endcase
        end
        case (kind)
            3'd0, 3'd1, 3'd2: opcode = {1'b0, low_r[5:0]};
            3'd3:             opcode = {3'b111, low_r[3:0]};
            3'd4:             opcode = {3'b110, low_r[3:0]};
            3'd5:             opcode = {4'b1000, low_r[2:0]};
            3'd6:             opcode = {4'b1001, low_r[2:0]};
            default:          opcode = {3'b101, low_r[3:0]};
        endcase
        cond = cond_r[3:0];
        flags = flag_r[3:0];
        {p, u, w, en_status_decode} = misc_r[3:0];
    endtask

    initial begin
        lfsr = 16'd8529;
        rst_n = 1'b0;
        opcode = '0;
        cond = '0;
        flags = '0;
        {p, u, w, en_status_decode} = 4'b0000;
        test_done = 1'b0;
        all_done = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // load_pc_start, then the first fetch
        repeat (2) @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < INSTR_PER_TEST; i++) begin
                drive_instr(t);
                @(negedge clk);
                test_done = 1'b0;
                repeat (6) @(negedge clk);
            end
            test_done = 1'b1;
        end
        @(negedge clk);
        test_done = 1'b0;
        all_done = 1'b1;
        @(negedge clk);
        if (error_count == 0 && check_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            if (check_count == 0) $display("no output was ever compared");
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the instruction sequence did not finish in %0d cycles",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- all.f
verilog/cpu_ctrl_pkg.sv
verilog/instr_if.sv
verilog/instr_classifier.sv
verilog/step_sequencer.sv
verilog/cond_check.sv
verilog/operand_control.sv
verilog/execute_control.sv
verilog/cpu_controller.sv
dv/ctrl_checker.sv
dv/tb_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = all.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)

run: build
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
